/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = tb_dcache
FILELIST  = sim.f

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

/* sim.f */
src/dcache_pkg.sv
src/dcache_set_if.sv
src/dcache_lookup.sv
src/dcache_store.sv
src/dcache_mem_ctrl.sv
src/dcache_top.sv
tests/dcache_checker.sv
tests/tb_dcache.sv

/* src/dcache_lookup.sv */
`timescale 1ns/10ps

module dcache_lookup (
    input  logic              CLK,
    input  logic              n_rst,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    output dcache_pkg::word_t dmem_load,
    output logic              dhit,
    output logic              miss,
    input  logic              ctrl_idle,
    dcache_set_if.client      cpu_port
);

    dcache_pkg::dcache_addr_u        addr;
    logic [dcache_pkg::ways-1:0]     way_hit;
    logic                            hit_way;
    logic                            req;
    dcache_pkg::dcache_frame_t       hit_frame;
    dcache_pkg::dcache_frame_t       new_frame;
    dcache_pkg::word_t               hit_word;
    dcache_pkg::word_t               load_q;

    assign addr.word    = dmem_addr;
    assign cpu_port.idx = addr.fields.idx;

    always_comb begin
        for (int w = 0; w < dcache_pkg::ways; w++) begin
            way_hit[w] = cpu_port.way_frames[w].valid &&
                         (cpu_port.way_frames[w].tag == addr.fields.tag);
        end
    end

    assign hit_way   = way_hit[1];
    assign hit_frame = cpu_port.way_frames[hit_way];
    assign hit_word  = hit_frame.data[addr.fields.blkoff];

    assign req  = dmem_ren | dmem_wen;
    assign dhit = ctrl_idle & req & (|way_hit);
    assign miss = ctrl_idle & req & ~(|way_hit);

    // store word merged into the hit block
    always_comb begin
        new_frame                          = hit_frame;
        new_frame.dirty                    = 1'b1;
        new_frame.data[addr.fields.blkoff] = dmem_store;
    end

    assign cpu_port.wr_en     = dhit & dmem_wen;
    assign cpu_port.wr_way    = hit_way;
    assign cpu_port.wr_frame  = new_frame;
    assign cpu_port.touch     = dhit;
    assign cpu_port.touch_way = hit_way;

    // last read word stays on dmem_load between hits
    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            load_q <= '0;
        end else if (dhit && dmem_ren) begin
            load_q <= hit_word;
        end
    end

    assign dmem_load = (dhit && dmem_ren) ? hit_word : load_q;

endmodule

/* src/dcache_mem_ctrl.sv */
`timescale 1ns/10ps

module dcache_mem_ctrl (
    input  logic              CLK,
    input  logic              n_rst,
    input  logic              miss,
    input  logic              halt,
    input  dcache_pkg::word_t dmem_addr,
    output logic              ctrl_idle,
    output logic              flushed,
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_store,
    input  dcache_pkg::word_t mem_load,
    input  logic              mem_wait,
    dcache_set_if.client      fill_port
);

    typedef enum logic [3:0] {
        IDLE, WB0, WB1, FILL0, FILL1, FLUSH_CHK, FLUSH0, FLUSH1, DONE
    } state_t;

    state_t                          state, next_state;
    dcache_pkg::dcache_addr_u        cpu_a;
    logic [dcache_pkg::idx_w-1:0]    flush_idx, next_flush_idx;
    logic                            flush_way, next_flush_way;
    dcache_pkg::word_t               fill_word0;
    logic                            next_ren, next_wen;
    dcache_pkg::word_t               next_addr, next_store;
    dcache_pkg::dcache_frame_t       victim, flush_frame;
    logic                            flush_mode;

    function automatic dcache_pkg::word_t blk_addr(
        input logic [dcache_pkg::tag_w-1:0] tag,
        input logic [dcache_pkg::idx_w-1:0] idx,
        input logic                         off
    );
        dcache_pkg::dcache_addr_u a;
        a.fields.tag     = tag;
        a.fields.idx     = idx;
        a.fields.blkoff  = off;
        a.fields.byteoff = '0;
        return a.word;
    endfunction

    assign cpu_a.word = dmem_addr;
    assign flush_mode = (state == FLUSH_CHK) || (state == FLUSH0) || (state == FLUSH1);
    assign fill_port.idx = flush_mode ? flush_idx : cpu_a.fields.idx;

    assign victim      = fill_port.way_frames[fill_port.lru];
    assign flush_frame = fill_port.way_frames[flush_way];

    assign ctrl_idle = (state == IDLE);
    assign flushed   = (state == DONE);

    always_comb begin
        next_state     = state;
        next_flush_idx = flush_idx;
        next_flush_way = flush_way;
        next_ren       = mem_ren;
        next_wen       = mem_wen;
        next_addr      = mem_addr;
        next_store     = mem_store;

        fill_port.wr_en     = 1'b0;
        fill_port.wr_way    = fill_port.lru;
        fill_port.wr_frame  = victim;
        fill_port.touch     = 1'b0;
        fill_port.touch_way = fill_port.lru;

        case (state)
            IDLE: begin
                if (halt) begin
                    next_state     = FLUSH_CHK;
                    next_flush_idx = '0;
                end else if (miss && victim.dirty) begin
                    next_state = WB0;
                    next_wen   = 1'b1;
                    next_addr  = blk_addr(victim.tag, cpu_a.fields.idx, 1'b0);
                    next_store = victim.data[0];
                end else if (miss) begin
                    next_state = FILL0;
                    next_ren   = 1'b1;
                    next_addr  = blk_addr(cpu_a.fields.tag, cpu_a.fields.idx, 1'b0);
                end
            end
            WB0: begin
                if (!mem_wait) begin
                    next_state = WB1;
                    next_addr  = blk_addr(victim.tag, cpu_a.fields.idx, 1'b1);
                    next_store = victim.data[1];
                end
            end
            WB1: begin
                if (!mem_wait) begin
                    next_state = FILL0;
                    next_wen   = 1'b0;
                    next_ren   = 1'b1;
                    next_addr  = blk_addr(cpu_a.fields.tag, cpu_a.fields.idx, 1'b0);
                end
            end
            FILL0: begin
                if (!mem_wait) begin
                    next_state = FILL1;
                    next_addr  = blk_addr(cpu_a.fields.tag, cpu_a.fields.idx, 1'b1);
                end
            end
            FILL1: begin
                if (!mem_wait) begin
                    next_state = IDLE;
                    next_ren   = 1'b0;
                    // clean block, a pending store merges next cycle as a hit
                    fill_port.wr_en    = 1'b1;
                    fill_port.wr_frame = {1'b1, 1'b0, cpu_a.fields.tag, mem_load, fill_word0};
                    fill_port.touch    = 1'b1;
                end
            end
            FLUSH_CHK: begin
                if (fill_port.way_frames[0].dirty || fill_port.way_frames[1].dirty) begin
                    next_flush_way = ~fill_port.way_frames[0].dirty;   // lower way first
                    next_state     = FLUSH0;
                    next_wen       = 1'b1;
                    next_addr      = blk_addr(fill_port.way_frames[next_flush_way].tag,
                                              flush_idx, 1'b0);
                    next_store     = fill_port.way_frames[next_flush_way].data[0];
                end else if (flush_idx == dcache_pkg::idx_w'(dcache_pkg::sets - 1)) begin
                    next_state = DONE;
                end else begin
                    next_flush_idx = flush_idx + 1'b1;
                end
            end
            FLUSH0: begin
                if (!mem_wait) begin
                    next_state = FLUSH1;
                    next_addr  = blk_addr(flush_frame.tag, flush_idx, 1'b1);
                    next_store = flush_frame.data[1];
                end
            end
            FLUSH1: begin
                if (!mem_wait) begin
                    next_state               = FLUSH_CHK;
                    next_wen                 = 1'b0;
                    fill_port.wr_en          = 1'b1;
                    fill_port.wr_way         = flush_way;
                    fill_port.wr_frame       = flush_frame;
                    fill_port.wr_frame.dirty = 1'b0;
                end
            end
            default: begin
                next_state = DONE;   // bus stays quiet
            end
        endcase
    end

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state     <= IDLE;
            flush_idx <= '0;
            flush_way <= 1'b0;
            mem_ren   <= 1'b0;
            mem_wen   <= 1'b0;
        end else begin
            state     <= next_state;
            flush_idx <= next_flush_idx;
            flush_way <= next_flush_way;
            mem_ren   <= next_ren;
            mem_wen   <= next_wen;
        end
    end

    always_ff @(posedge CLK) begin
        mem_addr  <= next_addr;
        mem_store <= next_store;
        if (state == FILL0 && !mem_wait) begin
            fill_word0 <= mem_load;
        end
    end

endmodule

/* src/dcache_pkg.sv */
package dcache_pkg;

    // geometry
    localparam int word_w     = 32;
    localparam int sets       = 8;
    localparam int idx_w      = 3;
    localparam int blk_words  = 2;
    localparam int ways       = 2;
    localparam int tag_w      = 26;
    localparam int byte_off_w = 2;

    typedef logic [word_w-1:0] word_t;

    // tag | idx | word in block | byte in word
    typedef struct packed {
        logic [tag_w-1:0]             tag;
        logic [idx_w-1:0]             idx;
        logic [$clog2(blk_words)-1:0] blkoff;
        logic [byte_off_w-1:0]        byteoff;
    } dcache_addr_s;

    // same 32 bits, seen whole or split into fields
    typedef union packed {
        word_t        word;
        dcache_addr_s fields;
    } dcache_addr_u;

    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [tag_w-1:0]            tag;
        word_t [blk_words-1:0]       data;   // data[0] is the lower word
    } dcache_frame_t;

endpackage

/* src/dcache_set_if.sv */
`timescale 1ns/10ps

interface dcache_set_if;

    logic [dcache_pkg::idx_w-1:0]                      idx;
    dcache_pkg::dcache_frame_t [dcache_pkg::ways-1:0]  way_frames;  // both ways of set idx
    logic                                              lru;         // way to replace next

    logic                                              wr_en;
    logic                                              wr_way;
    dcache_pkg::dcache_frame_t                         wr_frame;

    logic                                              touch;
    logic                                              touch_way;

    modport array (
        input  idx, wr_en, wr_way, wr_frame, touch, touch_way,
        output way_frames, lru
    );

    modport client (
        output idx, wr_en, wr_way, wr_frame, touch, touch_way,
        input  way_frames, lru
    );

endinterface

/* src/dcache_store.sv */
`timescale 1ns/10ps

module dcache_store (
    input  logic         CLK,
    input  logic         n_rst,
    dcache_set_if.array  cpu_port,
    dcache_set_if.array  fill_port
);

    dcache_pkg::dcache_frame_t [dcache_pkg::ways-1:0] frames [dcache_pkg::sets];
    logic [dcache_pkg::sets-1:0]                      lru_bits;

    // combinational read, one set per port
    assign cpu_port.way_frames  = frames[cpu_port.idx];
    assign cpu_port.lru         = lru_bits[cpu_port.idx];
    assign fill_port.way_frames = frames[fill_port.idx];
    assign fill_port.lru        = lru_bits[fill_port.idx];

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < dcache_pkg::sets; i++) begin
                frames[i] <= '0;
            end
            lru_bits <= '0;
        end else begin
            if (cpu_port.wr_en) begin
                frames[cpu_port.idx][cpu_port.wr_way] <= cpu_port.wr_frame;
            end
            if (cpu_port.touch) begin
                lru_bits[cpu_port.idx] <= ~cpu_port.touch_way;
            end
            // controller port last, so it wins on a collision
            if (fill_port.wr_en) begin
                frames[fill_port.idx][fill_port.wr_way] <= fill_port.wr_frame;
            end
            if (fill_port.touch) begin
                lru_bits[fill_port.idx] <= ~fill_port.touch_way;
            end
        end
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top (
    input  logic              CLK,
    input  logic              n_rst,
    // CPU side
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    output dcache_pkg::word_t dmem_load,
    output logic              dhit,
    input  logic              halt,
    output logic              flushed,
    // memory side
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_store,
    input  dcache_pkg::word_t mem_load,
    input  logic              mem_wait
);

    logic ctrl_idle;
    logic miss;

    dcache_set_if cpu_port ();
    dcache_set_if fill_port ();

    dcache_lookup lookup0 (
        .CLK        (CLK),
        .n_rst      (n_rst),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .miss       (miss),
        .ctrl_idle  (ctrl_idle),
        .cpu_port   (cpu_port.client)
    );

    dcache_store store0 (
        .CLK       (CLK),
        .n_rst     (n_rst),
        .cpu_port  (cpu_port.array),
        .fill_port (fill_port.array)
    );

    dcache_mem_ctrl ctrl0 (
        .CLK       (CLK),
        .n_rst     (n_rst),
        .miss      (miss),
        .halt      (halt),
        .dmem_addr (dmem_addr),
        .ctrl_idle (ctrl_idle),
        .flushed   (flushed),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_store (mem_store),
        .mem_load  (mem_load),
        .mem_wait  (mem_wait),
        .fill_port (fill_port.client)
    );

endmodule

/* tests/dcache_checker.sv */
`timescale 1ns/10ps

module dcache_checker (
    input  logic              CLK,
    input  logic              n_rst,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    input  dcache_pkg::word_t dmem_load,
    input  logic              dhit,
    input  logic              flushed,
    input  logic              mem_ren,
    input  logic              mem_wen,
    input  dcache_pkg::word_t mem_addr,
    input  dcache_pkg::word_t mem_store,
    input  logic              mem_wait,
    input  dcache_pkg::word_t mem_image [64],
    input  int                test_no,
    input  logic              test_end,
    output int                errors
);

    dcache_pkg::word_t golden [64];   // preload plus every write accepted with dhit
    int                test_start;
    int                passed;
    int                failed;
    logic              flush_seen;

    function automatic string test_name(input int n);
        case (n)
            1: return "cold reads";
            2: return "write then read";
            3: return "eviction";
            4: return "random traffic";
            5: return "flush";
            default: return "unknown";
        endcase
    endfunction

    always @(posedge CLK) begin
        if (!n_rst) begin
            golden     = mem_image;
            errors     = 0;
            test_start = 0;
            passed     = 0;
            failed     = 0;
            flush_seen = 1'b0;
        end else begin
            if (mem_ren && mem_wen) begin
                $display("%0t: mem_ren and mem_wen are high in the same cycle", $time);
                errors++;
            end
            if (flushed && (mem_ren || mem_wen)) begin
                $display("%0t: memory bus is active after flushed went high", $time);
                errors++;
            end
            if ((mem_ren || mem_wen) && (mem_addr[31:8] != '0 || mem_addr[1:0] != '0)) begin
                $display("%0t: memory address %h is outside the model or unaligned",
                         $time, mem_addr);
                errors++;
            end
            // write-backs must carry the latest CPU data
            if (mem_wen && !mem_wait && mem_store !== golden[mem_addr[7:2]]) begin
                $display("Mismatch at %0t: write-back to %h carries %h, expected %h",
                         $time, mem_addr, mem_store, golden[mem_addr[7:2]]);
                errors++;
            end
            if (dhit && dmem_ren && dmem_load !== golden[dmem_addr[7:2]]) begin
                $display("Mismatch at %0t: read of %h returned %h, expected %h",
                         $time, dmem_addr, dmem_load, golden[dmem_addr[7:2]]);
                errors++;
            end
            if (dhit && dmem_wen) begin
                golden[dmem_addr[7:2]] = dmem_store;
            end
            if (flushed && !flush_seen) begin
                flush_seen = 1'b1;
                for (int i = 0; i < 64; i++) begin
                    if (mem_image[i] !== golden[i]) begin
                        $display("Mismatch at %0t: memory word %0d is %h after flush, expected %h",
                                 $time, i, mem_image[i], golden[i]);
                        errors++;
                    end
                end
            end
            if (test_end) begin
                if (errors == test_start) begin
                    passed++;
                    $display("test %0d %s: pass", test_no, test_name(test_no));
                end else begin
                    failed++;
                    $display("test %0d %s: FAIL with %0d errors", test_no,
                             test_name(test_no), errors - test_start);
                end
                test_start = errors;
                if (test_no == 5) begin
                    $display("summary: %0d passed, %0d failed, %0d errors",
                             passed, failed, errors);
                end
            end
        end
    end

endmodule

/* tests/tb_dcache.sv */
`timescale 1ns/10ps

module tb_dcache;

    localparam int n_requests = 8 + 6 + 6 + 300;
    localparam int max_cycles = n_requests * 22 + 8 * 2 * 8 + 100;

    logic              CLK;
    logic              n_rst;
    logic              dmem_ren, dmem_wen, dhit, halt, flushed;
    dcache_pkg::word_t dmem_addr, dmem_store, dmem_load;
    logic              mem_ren, mem_wen, mem_wait;
    dcache_pkg::word_t mem_addr, mem_store, mem_load;
    dcache_pkg::word_t mem [64];   // tags 0 to 3
    int                wait_left;  // -1 when no transfer is in progress
    int                test_no;
    logic              test_end;
    int                errors;

    dcache_top dut0 (.*);

    dcache_checker chk0 (.*, .mem_image(mem));

    always #20 CLK = ~CLK;

    function automatic dcache_pkg::word_t make_addr(input logic [1:0] tag,
                                                    input logic [2:0] idx,
                                                    input logic       off);
        return {24'd0, tag, idx, off, 2'b00};
    endfunction

    // one CPU request, held until dhit
    task automatic access(input logic wr, input dcache_pkg::word_t addr,
                          input dcache_pkg::word_t data);
        @(negedge CLK);
        dmem_ren   = ~wr;
        dmem_wen   = wr;
        dmem_addr  = addr;
        dmem_store = data;
        do @(posedge CLK); while (!dhit);
        @(negedge CLK);
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
    endtask

    task automatic close_test();
        @(negedge CLK);
        test_end = 1'b1;
        @(negedge CLK);
        test_end = 1'b0;
    endtask

    // memory model, 0 to 3 wait cycles per word
    always @(negedge CLK) begin
        if (mem_ren || mem_wen) begin
            if (wait_left < 0) begin
                wait_left = int'($urandom % 4);
            end
            mem_wait = (wait_left != 0);
            if (wait_left == 0) begin
                mem_load  = mem[mem_addr[7:2]];
                wait_left = -1;   // taken at the next rising edge
            end else begin
                wait_left--;
            end
        end else begin
            mem_wait = 1'b0;
        end
    end

    always @(posedge CLK) begin
        if (mem_wen && !mem_wait) begin
            mem[mem_addr[7:2]] <= mem_store;
        end
    end

    initial begin
        void'($urandom(32'h92ffce5a));
        CLK        = 1'b0;
        n_rst      = 1'b0;
        dmem_ren   = 1'b0;
        dmem_wen   = 1'b0;
        dmem_addr  = '0;
        dmem_store = '0;
        halt       = 1'b0;
        mem_load   = '0;
        mem_wait   = 1'b0;
        wait_left  = -1;
        test_no    = 0;
        test_end   = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = $urandom;
        end
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        n_rst = 1'b1;

        test_no = 1;
        for (int i = 0; i < 8; i++) begin
            access(1'b0, make_addr(2'(i % 4), 3'(i), 1'(i % 2)), '0);
        end
        close_test();

        test_no = 2;   // write miss, then hit on both words
        for (int b = 0; b < 2; b++) begin
            access(1'b1, make_addr(2'(b + 1), 3'd6, 1'b0), $urandom);
            access(1'b0, make_addr(2'(b + 1), 3'd6, 1'b0), '0);
            access(1'b0, make_addr(2'(b + 1), 3'd6, 1'b1), '0);
        end
        close_test();

        test_no = 3;   // three tags in a two-way set
        for (int t = 1; t < 4; t++) begin
            access(1'b1, make_addr(2'(t), 3'd5, 1'b0), $urandom);
        end
        for (int t = 1; t < 4; t++) begin
            access(1'b0, make_addr(2'(t), 3'd5, 1'b0), '0);
        end
        close_test();

        test_no = 4;
        for (int n = 0; n < 300; n++) begin
            access(1'($urandom % 2),
                   make_addr(2'($urandom % 4), 3'($urandom % 3), 1'($urandom % 2)),
                   $urandom);
        end
        close_test();

        test_no = 5;
        @(negedge CLK);
        halt = 1'b1;
        do @(posedge CLK); while (!flushed);
        repeat (4) @(posedge CLK);   // bus must stay quiet
        close_test();

        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("tests failed");
        $finish;
    end

endmodule
